// ==== rv32iPkg.sv ====
`default_nettype none

// ******************************
// Shared types and defaults of the fetch front end
// ******************************

package rv32iPkg;

    // Machine word, used for addresses and data
    typedef logic [31:0] word_t;

    // One instruction queue entry
    // PC sits in the upper half
    typedef struct packed {
        word_t pc;
        word_t inst;
    } fetchEntry_t;

    // Route tag for one outstanding memory access
    // Port 0 is fetch and port 1 is data
    typedef struct packed {
        logic port;
        logic epoch;
    } routeTag_t;

    // Default reset PC
    parameter word_t RESET_VECTOR_DEF = 32'h0000_0000;

    // Default instruction queue depth, also the fetch credit limit
    parameter int QUEUE_DEPTH_DEF = 4;

    // Default memory size in words
    parameter int MEM_WORDS_DEF = 1024;

endpackage

`default_nettype wire

// ==== syncFifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module syncFifo #(
    parameter type payload_t = logic,
    parameter int  depth     = 2
) (
    input  wire           Clk,
    input  wire           rst,
    input  wire           flush,
    input  wire           inValid,
    output logic          inReady,
    input  wire payload_t inData,
    output logic          outValid,
    input  wire           outReady,
    output payload_t      outData
);

    // Pointer width kept at one bit or more for a single-entry buffer
    localparam int ptrW = (depth > 1) ? $clog2(depth) : 1;
    localparam int cntW = $clog2(depth + 1);

    payload_t        slots [depth];
    logic [ptrW-1:0] rdPtr;
    logic [ptrW-1:0] wrPtr;
    logic [cntW-1:0] count;
    logic            push;
    logic            pop;

    // Wrap at the last slot, depth need not be a power of two
    function automatic logic [ptrW-1:0] nextPtr(input logic [ptrW-1:0] ptr);
        return (ptr == ptrW'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Handshake status straight from the occupancy count
    assign inReady  = (count < depth);
    assign outValid = (count != '0);
    assign outData  = slots[rdPtr];
    assign push     = inValid && inReady;
    assign pop      = outValid && outReady;

    // Payload storage
    always_ff @(posedge Clk) begin
        if (push) begin
            slots[wrPtr] <= inData;
        end
    end

    // ******************************
    // Pointers and count
    // ******************************
    always_ff @(posedge Clk) begin
        if (rst || flush) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            // Simultaneous push and pop keeps the count
            count <= count + cntW'(push) - cntW'(pop);
        end
    end

    // Occupancy never runs past the buffer size
    noOverflow: assert property (@(posedge Clk) disable iff (rst) count <= depth);

    // A lone pop shrinks the count, no wrap below empty
    noUnderflow: assert property (@(posedge Clk) disable iff (rst)
        pop && !push && !flush |=> count < $past(count));

endmodule

`default_nettype wire

// ==== fetchCtrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetchCtrl #(
    parameter rv32iPkg::word_t resetVector = rv32iPkg::RESET_VECTOR_DEF,
    parameter int              queueDepth  = rv32iPkg::QUEUE_DEPTH_DEF
) (
    input  wire                   Clk,
    input  wire                   rst,
    // Redirects from decode and execute
    input  wire                   idJump,
    input  wire rv32iPkg::word_t  idJumpDest,
    input  wire                   exBranch,
    input  wire rv32iPkg::word_t  exBranchDest,
    // Request side toward the arbiter
    output logic                  fetchReqValid,
    input  wire                   fetchReqReady,
    output rv32iPkg::word_t       fetchReqAddr,
    output logic                  fetchReqEpoch,
    // Response side from the arbiter
    input  wire                   fetchRspValid,
    output logic                  fetchRspReady,
    input  wire rv32iPkg::word_t  fetchRspData,
    input  wire                   fetchRspEpoch,
    // Instruction queue
    output logic                  queuePushValid,
    input  wire                   queuePushReady,
    output rv32iPkg::fetchEntry_t queuePushData,
    input  wire                   queuePop,
    output logic                  queueFlush
);

    localparam int ptrW = (queueDepth > 1) ? $clog2(queueDepth) : 1;
    localparam int cntW = $clog2(queueDepth + 1);

    rv32iPkg::word_t pc;
    logic            epoch;
    logic            fetchEnable;
    // PCs of in-flight requests, oldest at pcRdPtr
    rv32iPkg::word_t pcSlots [queueDepth];
    logic [ptrW-1:0] pcRdPtr;
    logic [ptrW-1:0] pcWrPtr;
    logic [cntW-1:0] inFlight;
    logic [cntW-1:0] queued;
    logic [cntW:0]   creditCount;
    logic            redirect;
    logic            reqFire;
    logic            rspFire;
    logic            stale;

    function automatic logic [ptrW-1:0] nextPtr(input logic [ptrW-1:0] ptr);
        return (ptr == ptrW'(queueDepth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign redirect   = idJump || exBranch;
    assign queueFlush = redirect;

    // Credits cover requests in flight plus entries already queued
    assign creditCount   = inFlight + queued;
    assign fetchReqValid = fetchEnable && (creditCount < queueDepth);
    assign fetchReqAddr  = pc;
    assign fetchReqEpoch = epoch;
    assign reqFire       = fetchReqValid && fetchReqReady;

    // Old epoch, or overtaken by a redirect at this very edge
    assign stale          = (fetchRspEpoch != epoch) || redirect;
    // Stale words are always taken so they can be thrown away
    assign fetchRspReady  = stale || queuePushReady;
    assign rspFire        = fetchRspValid && fetchRspReady;
    assign queuePushValid = fetchRspValid && !stale;
    assign queuePushData  = '{pc: pcSlots[pcRdPtr], inst: fetchRspData};

    // ******************************
    // PC and epoch
    // ******************************
    always_ff @(posedge Clk) begin
        if (rst) begin
            pc          <= resetVector;
            epoch       <= 1'b0;
            fetchEnable <= 1'b0;
        end else begin
            // First request one cycle after reset
            fetchEnable <= 1'b1;
            // Jump beats branch, both beat sequential advance
            if (idJump) begin
                pc <= idJumpDest;
            end else if (exBranch) begin
                pc <= exBranchDest;
            end else if (reqFire) begin
                pc <= pc + 32'd4;
            end
            if (redirect) begin
                epoch <= !epoch;
            end
        end
    end

    // Remember the PC of each accepted request
    always_ff @(posedge Clk) begin
        if (reqFire) begin
            pcSlots[pcWrPtr] <= pc;
        end
    end

    // ******************************
    // In-flight and queue counts
    // ******************************
    always_ff @(posedge Clk) begin
        if (rst) begin
            pcRdPtr  <= '0;
            pcWrPtr  <= '0;
            inFlight <= '0;
            queued   <= '0;
        end else begin
            if (reqFire) begin
                pcWrPtr <= nextPtr(pcWrPtr);
            end
            if (rspFire) begin
                pcRdPtr <= nextPtr(pcRdPtr);
            end
            // Dropped stale words release their credit here too
            inFlight <= inFlight + cntW'(reqFire) - cntW'(rspFire);
            if (redirect) begin
                // Flush returns every queued credit at once
                queued <= '0;
            end else begin
                queued <= queued + cntW'(queuePushValid && queuePushReady) - cntW'(queuePop);
            end
        end
    end

    creditBound: assert property (@(posedge Clk) disable iff (rst)
        creditCount <= queueDepth);

    // Credit limit leaves queue room for every live response
    pushHasRoom: assert property (@(posedge Clk) disable iff (rst)
        queuePushValid |-> queuePushReady);

endmodule

`default_nettype wire

// ==== memArbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module memArbiter (
    input  wire                  Clk,
    input  wire                  rst,
    // Port 0, instruction fetch
    input  wire                  fetchReqValid,
    output logic                 fetchReqReady,
    input  wire rv32iPkg::word_t fetchReqAddr,
    input  wire                  fetchReqEpoch,
    output logic                 fetchRspValid,
    input  wire                  fetchRspReady,
    output rv32iPkg::word_t      fetchRspData,
    output logic                 fetchRspEpoch,
    // Port 1, data load/store
    input  wire                  dataReqValid,
    output logic                 dataReqReady,
    input  wire                  dataReqWrite,
    input  wire rv32iPkg::word_t dataReqAddr,
    input  wire rv32iPkg::word_t dataReqWdata,
    output logic                 dataRspValid,
    input  wire                  dataRspReady,
    output rv32iPkg::word_t      dataRspRdata,
    // Memory side
    output logic                 memReqValid,
    input  wire                  memReqReady,
    output logic                 memReqWrite,
    output rv32iPkg::word_t      memReqAddr,
    output rv32iPkg::word_t      memReqWdata,
    input  wire                  memRspValid,
    output logic                 memRspReady,
    input  wire rv32iPkg::word_t memRspRdata
);

    logic                selData;
    // High when the data port won the last grant
    logic                lastGrant;
    logic                memReqFire;
    logic                routeInReady;
    logic                routeOutValid;
    rv32iPkg::routeTag_t routeNew;
    rv32iPkg::routeTag_t routeHead;

    // ******************************
    // Request side
    // ******************************

    // Data wins alone or when fetch had the last turn
    assign selData     = dataReqValid && (!fetchReqValid || !lastGrant);
    // No issue without a free routing slot
    assign memReqValid = (fetchReqValid || dataReqValid) && routeInReady;
    assign memReqWrite = selData && dataReqWrite;
    assign memReqAddr  = selData ? dataReqAddr : fetchReqAddr;
    // Fetch never writes
    assign memReqWdata = dataReqWdata;
    assign memReqFire  = memReqValid && memReqReady;

    assign fetchReqReady = memReqFire && !selData;
    assign dataReqReady  = memReqFire && selData;

    assign routeNew = '{port: selData, epoch: fetchReqEpoch};

    // Reset value hands the first tie to fetch
    always_ff @(posedge Clk) begin
        if (rst) begin
            lastGrant <= 1'b1;
        end else if (memReqFire) begin
            lastGrant <= selData;
        end
    end

    // One tag per issued access, in memory order
    syncFifo #(
        .payload_t(rv32iPkg::routeTag_t),
        .depth    (2)
    ) routeFifo (
        .Clk     (Clk),
        .rst     (rst),
        .flush   (1'b0),
        .inValid (memReqFire),
        .inReady (routeInReady),
        .inData  (routeNew),
        .outValid(routeOutValid),
        .outReady(memRspValid && memRspReady),
        .outData (routeHead)
    );

    // ******************************
    // Response steering by head tag
    // ******************************
    assign fetchRspValid = memRspValid && !routeHead.port;
    assign fetchRspData  = memRspRdata;
    assign fetchRspEpoch = routeHead.epoch;
    assign dataRspValid  = memRspValid && routeHead.port;
    assign dataRspRdata  = memRspRdata;
    // Owner of the head response decides the drain
    assign memRspReady   = routeHead.port ? dataRspReady : fetchRspReady;

    oneGrant: assert property (@(posedge Clk) disable iff (rst)
        !(fetchReqReady && dataReqReady));

    // A waiting data request takes the next turn over fetch
    dataTurn: assert property (@(posedge Clk) disable iff (rst)
        fetchReqReady && dataReqValid |=> !fetchReqReady);

    // Every memory response finds its tag waiting
    tagPresent: assert property (@(posedge Clk) disable iff (rst)
        memRspValid |-> routeOutValid);

endmodule

`default_nettype wire

// ==== unifiedMem.sv ====
`timescale 1ns/1ps
`default_nettype none

module unifiedMem #(
    parameter int memWords = rv32iPkg::MEM_WORDS_DEF
) (
    input  wire                  Clk,
    input  wire                  rst,
    input  wire                  reqValid,
    output logic                 reqReady,
    input  wire                  reqWrite,
    input  wire rv32iPkg::word_t reqAddr,
    input  wire rv32iPkg::word_t reqWdata,
    output logic                 rspValid,
    input  wire                  rspReady,
    output rv32iPkg::word_t      rspRdata
);

    localparam int addrW = $clog2(memWords);

    rv32iPkg::word_t  words [memWords];
    logic [addrW-1:0] index;
    logic             reqFire;

    // Word address with the byte offset bits dropped
    assign index = reqAddr[addrW+1:2];

    // Room while the response slot is empty or leaving this cycle
    assign reqReady = !rspValid || rspReady;
    assign reqFire  = reqValid && reqReady;

    // ******************************
    // Array and response data
    // ******************************
    always_ff @(posedge Clk) begin
        if (reqFire) begin
            // Old contents come back on writes as well
            rspRdata <= words[index];
            if (reqWrite) begin
                words[index] <= reqWdata;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (rst) begin
            rspValid <= 1'b0;
        end else if (reqFire) begin
            rspValid <= 1'b1;
        end else if (rspReady) begin
            rspValid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== fetchTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetchTop #(
    parameter rv32iPkg::word_t resetVector = rv32iPkg::RESET_VECTOR_DEF,
    parameter int              queueDepth  = rv32iPkg::QUEUE_DEPTH_DEF,
    parameter int              memWords    = rv32iPkg::MEM_WORDS_DEF
) (
    input  wire                  Clk,
    input  wire                  rst,
    input  wire                  idJump,
    input  wire rv32iPkg::word_t idJumpDest,
    input  wire                  exBranch,
    input  wire rv32iPkg::word_t exBranchDest,
    // Fetched instructions toward decode
    output wire                  instValid,
    input  wire                  instReady,
    output wire rv32iPkg::word_t instPc,
    output wire rv32iPkg::word_t instData,
    // Outside data port
    input  wire                  dataReqValid,
    output wire                  dataReqReady,
    input  wire                  dataReqWrite,
    input  wire rv32iPkg::word_t dataReqAddr,
    input  wire rv32iPkg::word_t dataReqWdata,
    output wire                  dataRspValid,
    input  wire                  dataRspReady,
    output wire rv32iPkg::word_t dataRspRdata
);

    // Fetch port between controller and arbiter
    wire                        fetchReqValid;
    wire                        fetchReqReady;
    wire rv32iPkg::word_t       fetchReqAddr;
    wire                        fetchReqEpoch;
    wire                        fetchRspValid;
    wire                        fetchRspReady;
    wire rv32iPkg::word_t       fetchRspData;
    wire                        fetchRspEpoch;
    // Queue push side
    wire                        queuePushValid;
    wire                        queuePushReady;
    wire rv32iPkg::fetchEntry_t queuePushData;
    wire                        queueFlush;
    // Entry leaves the queue
    wire                        queuePop = instValid && instReady;
    // Memory bus
    wire                        memReqValid;
    wire                        memReqReady;
    wire                        memReqWrite;
    wire rv32iPkg::word_t       memReqAddr;
    wire rv32iPkg::word_t       memReqWdata;
    wire                        memRspValid;
    wire                        memRspReady;
    wire rv32iPkg::word_t       memRspRdata;

    fetchCtrl #(
        .resetVector(resetVector),
        .queueDepth (queueDepth)
    ) ctrl (
        .Clk           (Clk),
        .rst           (rst),
        .idJump        (idJump),
        .idJumpDest    (idJumpDest),
        .exBranch      (exBranch),
        .exBranchDest  (exBranchDest),
        .fetchReqValid (fetchReqValid),
        .fetchReqReady (fetchReqReady),
        .fetchReqAddr  (fetchReqAddr),
        .fetchReqEpoch (fetchReqEpoch),
        .fetchRspValid (fetchRspValid),
        .fetchRspReady (fetchRspReady),
        .fetchRspData  (fetchRspData),
        .fetchRspEpoch (fetchRspEpoch),
        .queuePushValid(queuePushValid),
        .queuePushReady(queuePushReady),
        .queuePushData (queuePushData),
        .queuePop      (queuePop),
        .queueFlush    (queueFlush)
    );

    // Instruction queue, entry unpacked straight onto the inst port
    syncFifo #(
        .payload_t(rv32iPkg::fetchEntry_t),
        .depth    (queueDepth)
    ) instQueue (
        .Clk     (Clk),
        .rst     (rst),
        .flush   (queueFlush),
        .inValid (queuePushValid),
        .inReady (queuePushReady),
        .inData  (queuePushData),
        .outValid(instValid),
        .outReady(instReady),
        .outData ({instPc, instData})
    );

    memArbiter arb (
        .Clk          (Clk),
        .rst          (rst),
        .fetchReqValid(fetchReqValid),
        .fetchReqReady(fetchReqReady),
        .fetchReqAddr (fetchReqAddr),
        .fetchReqEpoch(fetchReqEpoch),
        .fetchRspValid(fetchRspValid),
        .fetchRspReady(fetchRspReady),
        .fetchRspData (fetchRspData),
        .fetchRspEpoch(fetchRspEpoch),
        .dataReqValid (dataReqValid),
        .dataReqReady (dataReqReady),
        .dataReqWrite (dataReqWrite),
        .dataReqAddr  (dataReqAddr),
        .dataReqWdata (dataReqWdata),
        .dataRspValid (dataRspValid),
        .dataRspReady (dataRspReady),
        .dataRspRdata (dataRspRdata),
        .memReqValid  (memReqValid),
        .memReqReady  (memReqReady),
        .memReqWrite  (memReqWrite),
        .memReqAddr   (memReqAddr),
        .memReqWdata  (memReqWdata),
        .memRspValid  (memRspValid),
        .memRspReady  (memRspReady),
        .memRspRdata  (memRspRdata)
    );

    unifiedMem #(
        .memWords(memWords)
    ) mem (
        .Clk     (Clk),
        .rst     (rst),
        .reqValid(memReqValid),
        .reqReady(memReqReady),
        .reqWrite(memReqWrite),
        .reqAddr (memReqAddr),
        .reqWdata(memReqWdata),
        .rspValid(memRspValid),
        .rspReady(memRspReady),
        .rspRdata(memRspRdata)
    );

endmodule

`default_nettype wire

// ==== tbClockGen.sv ====
`timescale 1ns/1ps
`default_nettype none

// ******************************
// Testbench clock and reset
// ******************************
module tbClockGen #(
    parameter int halfPeriod  = 10,
    parameter int resetCycles = 10
) (
    output logic Clk,
    output logic rst
);

    // 20 ns period with the default half period
    initial begin
        Clk = 1'b0;
        forever #(halfPeriod) Clk = !Clk;
    end

    // Reset drops shortly after the last reset edge
    initial begin
        rst = 1'b1;
        repeat (resetCycles) @(posedge Clk);
        #2;
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// ==== fetchTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetchTb;

    localparam int resetCycles = 10;
    // Tests need about 1200 cycles, limit leaves a wide margin
    localparam int timeoutCycles = 4000;
    // Words filled through the data port
    localparam int modelWords = 64;

    logic                  Clk;
    logic                  rst;
    logic                  idJump;
    rv32iPkg::word_t       idJumpDest;
    logic                  exBranch;
    rv32iPkg::word_t       exBranchDest;
    logic                  instValid;
    logic                  instReady;
    rv32iPkg::word_t       instPc;
    rv32iPkg::word_t       instData;
    logic                  dataReqValid;
    logic                  dataReqReady;
    logic                  dataReqWrite;
    rv32iPkg::word_t       dataReqAddr;
    rv32iPkg::word_t       dataReqWdata;
    logic                  dataRspValid;
    logic                  dataRspReady;
    rv32iPkg::word_t       dataRspRdata;

    // Model memory and bookkeeping
    rv32iPkg::word_t modelMem [modelWords];
    logic [31:0]     lfsr;
    rv32iPkg::word_t streamPc;
    int              cycleCount = 0;
    int              errorCount;
    int              testCount;
    int              testErrors;

    tbClockGen #(
        .halfPeriod (10),
        .resetCycles(resetCycles)
    ) clkGen (
        .Clk(Clk),
        .rst(rst)
    );

    fetchTop uut (
        .Clk         (Clk),
        .rst         (rst),
        .idJump      (idJump),
        .idJumpDest  (idJumpDest),
        .exBranch    (exBranch),
        .exBranchDest(exBranchDest),
        .instValid   (instValid),
        .instReady   (instReady),
        .instPc      (instPc),
        .instData    (instData),
        .dataReqValid(dataReqValid),
        .dataReqReady(dataReqReady),
        .dataReqWrite(dataReqWrite),
        .dataReqAddr (dataReqAddr),
        .dataReqWdata(dataReqWdata),
        .dataRspValid(dataRspValid),
        .dataRspReady(dataRspReady),
        .dataRspRdata(dataRspRdata)
    );

    // ******************************
    // Timeout watchdog
    // ******************************
    always @(posedge Clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("Timeout: run did not finish within %0d cycles", timeoutCycles);
            $display("Done: errors found");
            $finish;
        end
    end

    // Galois step, taps of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] galoisStep(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    // One LFSR step per bit taken
    task automatic takeRandBits(input int n, output rv32iPkg::word_t bits);
        int i;
        bits = '0;
        for (i = 0; i < n; i++) begin
            bits = {bits[30:0], lfsr[0]};
            lfsr = galoisStep(lfsr);
        end
    endtask

    // Expected queue entry for a PC inside the filled region
    function automatic rv32iPkg::fetchEntry_t modelEntry(input rv32iPkg::word_t pc);
        return '{pc: pc, inst: modelMem[pc[7:2]]};
    endfunction

    // ******************************
    // Compare and report
    // ******************************
    task automatic checkWord(input string name, input rv32iPkg::word_t expected,
                             input rv32iPkg::word_t actual);
        if (actual !== expected) begin
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic checkEntry(input string name, input rv32iPkg::fetchEntry_t expected,
                              input rv32iPkg::fetchEntry_t actual);
        if (actual !== expected) begin
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic flagFailure(input string msg);
        $display("Failure: %s", msg);
        errorCount++;
    endtask

    task automatic beginTest();
        testErrors = errorCount;
    endtask

    task automatic endTest(input string name);
        testCount++;
        $display("Test %s finished with %0d errors", name, errorCount - testErrors);
    endtask

    // ******************************
    // Bus helpers
    // ******************************

    // Drive point, 2 ns after the rising edge
    task automatic tick();
        @(posedge Clk);
        #2;
    endtask

    // Single data access, waits for grant and then the response
    task automatic dataAccess(input logic write, input rv32iPkg::word_t addr,
                              input rv32iPkg::word_t wdata, output rv32iPkg::word_t rdata);
        dataReqValid = 1'b1;
        dataReqWrite = write;
        dataReqAddr  = addr;
        dataReqWdata = wdata;
        @(negedge Clk);
        while (!dataReqReady) begin
            @(negedge Clk);
        end
        tick();
        dataReqValid = 1'b0;
        @(negedge Clk);
        while (!dataRspValid) begin
            @(negedge Clk);
        end
        rdata = dataRspRdata;
        tick();
    endtask

    // Accept one queue entry, ready stays high afterwards
    task automatic takeInst(output rv32iPkg::fetchEntry_t entry);
        instReady = 1'b1;
        @(negedge Clk);
        while (!instValid) begin
            @(negedge Clk);
        end
        entry = '{pc: instPc, inst: instData};
        tick();
    endtask

    // One-cycle redirect pulse
    task automatic pulseRedirect(input logic jump, input rv32iPkg::word_t jumpDest,
                                 input logic branch, input rv32iPkg::word_t branchDest);
        idJump       = jump;
        idJumpDest   = jumpDest;
        exBranch     = branch;
        exBranchDest = branchDest;
        tick();
        idJump   = 1'b0;
        exBranch = 1'b0;
    endtask

    // ******************************
    // Tests
    // ******************************
    task automatic testReset();
        beginTest();
        // Reset cycles plus the first free cycle
        repeat (resetCycles + 1) begin
            @(negedge Clk);
            if (instValid !== 1'b0 || dataRspValid !== 1'b0) begin
                flagFailure("valid output high during or just after reset");
            end
        end
        tick();
        @(negedge Clk);
        while (!instValid) begin
            @(negedge Clk);
        end
        checkWord("reset pc", rv32iPkg::RESET_VECTOR_DEF, instPc);
        tick();
        endTest("reset");
    endtask

    task automatic testDataPort();
        rv32iPkg::word_t w;
        rv32iPkg::word_t rdata;
        int              i;
        beginTest();
        for (i = 0; i < modelWords; i++) begin
            takeRandBits(32, w);
            modelMem[i] = w;
            dataAccess(1'b1, i * 4, w, rdata);
        end
        for (i = 0; i < modelWords; i++) begin
            dataAccess(1'b0, i * 4, '0, rdata);
            checkWord($sformatf("data read %0d", i), modelMem[i], rdata);
        end
        endTest("data port");
    endtask

    task automatic testSequential();
        rv32iPkg::fetchEntry_t entry;
        rv32iPkg::word_t       expected;
        int                    i;
        beginTest();
        // Throw away words prefetched before memory was filled
        pulseRedirect(1'b1, rv32iPkg::RESET_VECTOR_DEF, 1'b0, '0);
        expected = rv32iPkg::RESET_VECTOR_DEF;
        for (i = 0; i < 40; i++) begin
            takeInst(entry);
            checkEntry($sformatf("sequential %0d", i), modelEntry(expected), entry);
            expected = expected + 32'd4;
        end
        instReady = 1'b0;
        endTest("sequential fetch");
    endtask

    task automatic testRedirect();
        rv32iPkg::fetchEntry_t entry;
        beginTest();
        // Let the queue fill so the flush has work to do
        repeat (5) tick();
        pulseRedirect(1'b1, 32'h80, 1'b0, '0);
        takeInst(entry);
        instReady = 1'b0;
        checkEntry("jump", modelEntry(32'h80), entry);
        repeat (5) tick();
        pulseRedirect(1'b0, '0, 1'b1, 32'h40);
        takeInst(entry);
        instReady = 1'b0;
        checkEntry("branch", modelEntry(32'h40), entry);
        repeat (5) tick();
        // Jump has priority over branch
        pulseRedirect(1'b1, 32'ha0, 1'b1, 32'h20);
        takeInst(entry);
        instReady = 1'b0;
        checkEntry("jump over branch", modelEntry(32'ha0), entry);
        streamPc = 32'ha4;
        endTest("redirect");
    endtask

    task automatic testBackPressure();
        rv32iPkg::fetchEntry_t entry;
        rv32iPkg::word_t       w;
        rv32iPkg::word_t       rdata;
        int                    start;
        int                    i;
        beginTest();
        instReady = 1'b0;
        start     = cycleCount;
        // Random word reads while decode stalls
        while (cycleCount - start < 30) begin
            takeRandBits(6, w);
            dataAccess(1'b0, {w[29:0], 2'b00}, '0, rdata);
            checkWord($sformatf("shared read %0d", w), modelMem[w[5:0]], rdata);
        end
        for (i = 0; i < 16; i++) begin
            takeInst(entry);
            checkEntry($sformatf("stream %0d", i), modelEntry(streamPc), entry);
            streamPc = streamPc + 32'd4;
        end
        instReady = 1'b0;
        endTest("back-pressure");
    endtask

    initial begin
        idJump       = 1'b0;
        idJumpDest   = '0;
        exBranch     = 1'b0;
        exBranchDest = '0;
        instReady    = 1'b0;
        dataReqValid = 1'b0;
        dataReqWrite = 1'b0;
        dataReqAddr  = '0;
        dataReqWdata = '0;
        dataRspReady = 1'b1;
        lfsr         = 32'hb6e;
        streamPc     = '0;
        errorCount   = 0;
        testCount    = 0;
        testErrors   = 0;
        testReset();
        testDataPort();
        testSequential();
        testRedirect();
        testBackPressure();
        $display("Summary: %0d tests run, %0d errors", testCount, errorCount);
        if (errorCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
rv32iPkg.sv
syncFifo.sv
fetchCtrl.sv
memArbiter.sv
unifiedMem.sv
fetchTop.sv
tbClockGen.sv
fetchTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= fetchTb
FILELIST  ?= filelist.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(filter %.sv,$(shell cat $(FILELIST)))
BIN  := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q '^Done: no errors$$' $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
